// File: hdl/dcache_cfg.svh
// size macros of the data cache
//   address, word and line widths, geometry and address field widths
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// datapath widths
`define DC_ADDR_W    32
`define DC_WORD_W    64
`define DC_LINE_W    128

// geometry, two ways of sixteen sets
`define DC_WAYS      2
`define DC_SETS      16

// address split: tag | index | offset
`define DC_OFFSET_W  4
`define DC_INDEX_W   4
`define DC_TAG_W     24
`define DC_BE_W      8

`endif

// File: hdl/dcache_pkg.sv
// shared types of the data cache
//   controller state enum, core and memory request/response structs
//   line and way mask types, word select helper
`include "dcache_cfg.svh"

package dcache_pkg;

  // number of address bits that pick a word inside a line
  localparam int unsigned WORD_OFF_W = `DC_OFFSET_W - $clog2(`DC_BE_W);

  typedef logic [`DC_LINE_W-1:0] line_t;
  typedef logic [`DC_WAYS-1:0]   way_mask_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    STORE_MEM,
    MISS_REQ,
    MISS_WAIT,
    BYPASS_REQ,
    BYPASS_WAIT
  } ctrl_state_e;

  // request from the core, byte address
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic                  we;
    logic [`DC_BE_W-1:0]   be;
    logic [`DC_WORD_W-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic [`DC_WORD_W-1:0] rdata;
  } core_rsp_t;

  // line set: whole line read, addr line aligned
  // line clear: single word, addr word aligned
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic                  we;
    logic                  line;
    logic [`DC_BE_W-1:0]   be;
    logic [`DC_WORD_W-1:0] wdata;
  } mem_req_t;

  // word reads come back in their own lane of the line
  typedef struct packed {
    line_t data;
  } mem_rsp_t;

  function automatic logic [`DC_WORD_W-1:0] line_word(line_t l, logic [WORD_OFF_W-1:0] off);
    return l[off*`DC_WORD_W +: `DC_WORD_W];
  endfunction

endpackage

// File: hdl/dcache_cfg_regs.sv
// enable configuration of the data cache
//   pending and active enable bits, flush request on re-enable
`timescale 1ns/1ps

module dcache_cfg_regs (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic cfg_we_i,
  input  logic cfg_enable_i,
  input  logic ctrl_idle_i,
  output logic cache_en_o,
  output logic flush_o
);

  // wanted value and the one the controller sees
  logic en_pend_q;
  logic en_q;
  logic apply;

  // only switch modes between accesses
  assign apply = ctrl_idle_i && (en_pend_q != en_q);

  // off -> on, lines may be stale after bypassed stores
  // valid bits clear on the same edge the cache comes back
  assign flush_o = apply && en_pend_q;

  assign cache_en_o = en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_pend_q <= 1'b1;
      en_q      <= 1'b1;
    end else begin
      if (cfg_we_i) begin
        en_pend_q <= cfg_enable_i;
      end
      if (apply) begin
        en_q <= en_pend_q;
      end
    end
  end

endmodule

// File: hdl/dcache_arrays.sv
// tag, valid and data storage of the two way data cache
//   registered lookup with hit detection, way and word select
//   byte enable write on a store hit, refill with victim selection
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_arrays
  import dcache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  rd_en_i,
  input  logic [`DC_ADDR_W-1:0] rd_addr_i,
  input  logic                  wr_hit_i,
  input  logic [`DC_BE_W-1:0]   wr_be_i,
  input  logic [`DC_WORD_W-1:0] wr_data_i,
  input  logic                  refill_i,
  input  line_t                 refill_line_i,
  output logic                  hit_o,
  output logic [`DC_WORD_W-1:0] rd_word_o
);

  localparam int unsigned TAG_LSB = `DC_OFFSET_W + `DC_INDEX_W;

  // storage
  logic [`DC_TAG_W-1:0]        tag_mem  [`DC_WAYS][`DC_SETS];
  line_t                       data_mem [`DC_WAYS][`DC_SETS];
  way_mask_t [`DC_SETS-1:0]    valid_q;
  // per set, way to replace when both are valid
  logic [`DC_SETS-1:0]         victim_q;

  // lookup registers, held until the next rd_en_i
  logic [`DC_INDEX_W-1:0] idx_q;
  logic [WORD_OFF_W-1:0]  woff_q;
  logic [`DC_TAG_W-1:0]   tag_q;
  way_mask_t              rd_valid_q;
  logic [`DC_TAG_W-1:0]   rd_tag_q  [`DC_WAYS];
  line_t                  rd_line_q [`DC_WAYS];

  logic [`DC_INDEX_W-1:0] rd_idx;
  way_mask_t              hit_way;
  way_mask_t              repl_way;
  line_t                  hit_line;

  assign rd_idx = rd_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];

  // ------------------------------------------------------------------------
  // lookup, read this cycle and compare in the next
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
    end else if (rd_en_i) begin
      rd_valid_q <= valid_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      idx_q  <= rd_idx;
      woff_q <= rd_addr_i[$clog2(`DC_BE_W) +: WORD_OFF_W];
      tag_q  <= rd_addr_i[TAG_LSB +: `DC_TAG_W];
      for (int w = 0; w < `DC_WAYS; w++) begin
        rd_tag_q[w]  <= tag_mem[w][rd_idx];
        rd_line_q[w] <= data_mem[w][rd_idx];
      end
    end
  end

  // tag compare and way select
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_way[w] = rd_valid_q[w] && (rd_tag_q[w] == tag_q);
      if (hit_way[w]) begin
        hit_line = rd_line_q[w];
      end
    end
  end

  assign hit_o     = |hit_way;
  assign rd_word_o = line_word(hit_line, woff_q);

  // ------------------------------------------------------------------------
  // replacement: lowest invalid way, else the victim bit
  // ------------------------------------------------------------------------
  always_comb begin
    repl_way = '0;
    repl_way[victim_q[idx_q]] = 1'b1;
    // walk down so the lowest invalid way wins
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[idx_q][w]) begin
        repl_way    = '0;
        repl_way[w] = 1'b1;
      end
    end
  end

  // line and tag writes
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (refill_i && repl_way[w]) begin
        tag_mem[w][idx_q]  <= tag_q;
        data_mem[w][idx_q] <= refill_line_i;
      end else if (wr_hit_i && hit_way[w]) begin
        // merge the store bytes into the addressed word
        for (int b = 0; b < `DC_BE_W; b++) begin
          if (wr_be_i[b]) begin
            data_mem[w][idx_q][woff_q*`DC_WORD_W + b*8 +: 8] <= wr_data_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // valid and victim bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (refill_i) begin
      valid_q[idx_q]  <= valid_q[idx_q] | repl_way;
      // two ways, so point at the one not just filled
      victim_q[idx_q] <= repl_way[0];
    end
  end

  // a refill never duplicates a resident tag
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_way))
    else $error("more than one way hit in set %0d", idx_q);

endmodule

// File: hdl/dcache_ctrl_fsm.sv
// controller of the blocking data cache
//   state machine for lookup, store update, refill, write-through and bypass
//   core response register and memory request generation
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl_fsm
  import dcache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cache_en_i,
  // core side
  input  core_req_t             core_req_i,
  input  logic                  core_req_valid_i,
  output logic                  core_req_ready_o,
  output core_rsp_t             core_rsp_o,
  output logic                  core_rsp_valid_o,
  // memory side
  output mem_req_t              mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  mem_rsp_t              mem_rsp_i,
  input  logic                  mem_rsp_valid_i,
  // arrays
  input  logic                  hit_i,
  input  logic [`DC_WORD_W-1:0] rd_word_i,
  output logic                  ctrl_idle_o,
  output logic                  rd_en_o,
  output logic [`DC_ADDR_W-1:0] rd_addr_o,
  output logic                  wr_hit_o,
  output logic [`DC_BE_W-1:0]   wr_be_o,
  output logic [`DC_WORD_W-1:0] wr_data_o,
  output logic                  refill_o,
  output line_t                 refill_line_o
);

  localparam int unsigned WORD_LSB = $clog2(`DC_BE_W);

  ctrl_state_e state_q, state_d;
  core_req_t   req_q;
  core_rsp_t   rsp_q, rsp_d;
  logic        rsp_valid_q, rsp_valid_d;
  logic        accept;

  // one request at a time, taken only in IDLE
  assign core_req_ready_o = (state_q == IDLE);
  assign ctrl_idle_o      = (state_q == IDLE);
  assign accept           = core_req_valid_i && core_req_ready_o;

  // array read starts with the accept, the compare lands in LOOKUP
  assign rd_en_o       = accept && cache_en_i;
  assign rd_addr_o     = core_req_i.addr;
  assign wr_hit_o      = (state_q == STORE_WRITE);
  assign wr_be_o       = req_q.be;
  assign wr_data_o     = req_q.wdata;
  assign refill_o      = (state_q == MISS_WAIT) && mem_rsp_valid_i;
  assign refill_line_o = mem_rsp_i.data;

  // ------------------------------------------------------------------------
  // memory request, built from the held request only
  // ------------------------------------------------------------------------
  always_comb begin
    mem_req_valid_o = state_q inside {MISS_REQ, BYPASS_REQ, STORE_MEM};
    mem_req_o.we    = req_q.we;
    mem_req_o.line  = (state_q == MISS_REQ);
    mem_req_o.be    = req_q.we ? req_q.be : '0;
    mem_req_o.wdata = req_q.wdata;
    mem_req_o.addr  = {req_q.addr[`DC_ADDR_W-1:WORD_LSB], {WORD_LSB{1'b0}}};
    // refills fetch the whole line
    if (state_q == MISS_REQ) begin
      mem_req_o.addr[`DC_OFFSET_W-1:0] = '0;
    end
  end

  // ------------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    rsp_valid_d = 1'b0;
    rsp_d       = '0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          if (cache_en_i) begin
            state_d = LOOKUP;
          end else if (core_req_i.we) begin
            // cache off, store goes straight out
            state_d = STORE_MEM;
          end else begin
            state_d = BYPASS_REQ;
          end
        end
      end
      LOOKUP: begin
        if (req_q.we) begin
          // write-through, no allocate on a miss
          state_d = hit_i ? STORE_WRITE : STORE_MEM;
        end else if (hit_i) begin
          state_d     = IDLE;
          rsp_valid_d = 1'b1;
          rsp_d.rdata = rd_word_i;
        end else begin
          state_d = MISS_REQ;
        end
      end
      STORE_WRITE: begin
        state_d = STORE_MEM;
      end
      STORE_MEM: begin
        // store is done once memory takes it, data stays zero
        if (mem_req_ready_i) begin
          state_d     = IDLE;
          rsp_valid_d = 1'b1;
        end
      end
      MISS_REQ: begin
        if (mem_req_ready_i) begin
          state_d = MISS_WAIT;
        end
      end
      BYPASS_REQ: begin
        if (mem_req_ready_i) begin
          state_d = BYPASS_WAIT;
        end
      end
      MISS_WAIT, BYPASS_WAIT: begin
        // refill and bypass both pick the word by its offset
        if (mem_rsp_valid_i) begin
          state_d     = IDLE;
          rsp_valid_d = 1'b1;
          rsp_d.rdata = line_word(mem_rsp_i.data, req_q.addr[WORD_LSB +: WORD_OFF_W]);
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= rsp_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= core_req_i;
    end
    if (rsp_valid_d) begin
      rsp_q <= rsp_d;
    end
  end

  assign core_rsp_o       = rsp_q;
  assign core_rsp_valid_o = rsp_valid_q;

  // memory sees a stable request until it is taken
  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("memory request dropped or changed before acceptance");

  // every response is followed by at least one idle cycle
  rsp_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_valid_o |=> !core_rsp_valid_o)
    else $error("core response valid in two consecutive cycles");

endmodule

// File: hdl/dcache_top.sv
// top level of the blocking data cache
//   configuration block, tag and data arrays, controller
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core port
  input  core_req_t core_req_i,
  input  logic      core_req_valid_i,
  output logic      core_req_ready_o,
  output core_rsp_t core_rsp_o,
  output logic      core_rsp_valid_o,
  // memory port
  output mem_req_t  mem_req_o,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  input  mem_rsp_t  mem_rsp_i,
  input  logic      mem_rsp_valid_i,
  // enable configuration
  input  logic      cfg_we_i,
  input  logic      cfg_enable_i
);

  // configuration to controller and arrays
  logic cache_en;
  logic flush;
  logic ctrl_idle;

  // controller to arrays
  logic                  rd_en;
  logic [`DC_ADDR_W-1:0] rd_addr;
  logic                  wr_hit;
  logic [`DC_BE_W-1:0]   wr_be;
  logic [`DC_WORD_W-1:0] wr_data;
  logic                  refill;
  line_t                 refill_line;
  logic                  hit;
  logic [`DC_WORD_W-1:0] rd_word;

  dcache_cfg_regs i_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_enable_i (cfg_enable_i),
    .ctrl_idle_i  (ctrl_idle),
    .cache_en_o   (cache_en),
    .flush_o      (flush)
  );

  dcache_arrays i_arrays (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush),
    .rd_en_i       (rd_en),
    .rd_addr_i     (rd_addr),
    .wr_hit_i      (wr_hit),
    .wr_be_i       (wr_be),
    .wr_data_i     (wr_data),
    .refill_i      (refill),
    .refill_line_i (refill_line),
    .hit_o         (hit),
    .rd_word_o     (rd_word)
  );

  dcache_ctrl_fsm i_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cache_en_i       (cache_en),
    .core_req_i       (core_req_i),
    .core_req_valid_i (core_req_valid_i),
    .core_req_ready_o (core_req_ready_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_i        (mem_rsp_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .hit_i            (hit),
    .rd_word_i        (rd_word),
    .ctrl_idle_o      (ctrl_idle),
    .rd_en_o          (rd_en),
    .rd_addr_o        (rd_addr),
    .wr_hit_o         (wr_hit),
    .wr_be_o          (wr_be),
    .wr_data_o        (wr_data),
    .refill_o         (refill),
    .refill_line_o    (refill_line)
  );

endmodule

// File: tb/tb_mem_model.sv
// memory responder for the data cache testbench
//   byte store filled with an address hash, random ready and latency
//   request log as read and write counters plus the last accepted request
`timescale 1ns/1ps

module tb_mem_model
  import dcache_pkg::*;
#(
  parameter logic [31:0] BASE = 32'h4000_0000,
  parameter logic [31:0] SEED = 32'h163f_d1db
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stall_i,
  input  mem_req_t    mem_req_i,
  input  logic        mem_req_valid_i,
  output logic        mem_req_ready_o,
  output mem_rsp_t    mem_rsp_o,
  output logic        mem_rsp_valid_o,
  output int unsigned line_rd_cnt_o,
  output int unsigned word_rd_cnt_o,
  output int unsigned wr_cnt_o,
  output mem_req_t    last_req_o
);

  // 4 KiB window starting at BASE, indexed by the low 12 address bits
  logic [7:0]  store_q [4096];
  logic [31:0] rnd_q;
  int unsigned wait_cnt;
  line_t       rsp_line;
  logic        take;
  mem_req_t    req;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every bit of the word address feeds the pattern
  function automatic logic [63:0] addr_hash(input logic [31:0] a);
    return {a * 32'h9e37_79b1, a ^ {a[15:0], a[31:16]} ^ 32'h5bd1_e995};
  endfunction

  initial begin
    logic [63:0] w;
    for (int i = 0; i < 512; i++) begin
      w = addr_hash(BASE | (i << 3));
      for (int b = 0; b < 8; b++) begin
        store_q[i*8 + b] = w[b*8 +: 8];
      end
    end
  end

  // ------------------------------------------------------------------------
  // sample at the edge, answer 1 ns later
  // ------------------------------------------------------------------------
  initial begin
    mem_req_ready_o = 1'b1;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_o       = '0;
    line_rd_cnt_o   = 0;
    word_rd_cnt_o   = 0;
    wr_cnt_o        = 0;
    last_req_o      = '0;
    rsp_line        = '0;
    rnd_q           = SEED;
    wait_cnt        = 0;
    forever begin
      @(posedge clk_i);
      take = rst_ni && mem_req_valid_i && mem_req_ready_o;
      req  = mem_req_i;
      #1;
      mem_rsp_valid_o = 1'b0;
      rnd_q = lcg_step(rnd_q);
      if (take) begin
        last_req_o = req;
        if (req.we) begin
          // write-through word, no response
          wr_cnt_o++;
          for (int b = 0; b < 8; b++) begin
            if (req.be[b]) begin
              store_q[{req.addr[11:3], 3'b000} + b] = req.wdata[b*8 +: 8];
            end
          end
        end else begin
          if (req.line) begin
            line_rd_cnt_o++;
          end else begin
            word_rd_cnt_o++;
          end
          // always the whole line, a word read lands in its own lane
          for (int b = 0; b < 16; b++) begin
            rsp_line[b*8 +: 8] = store_q[{req.addr[11:4], 4'b0000} + b];
          end
          wait_cnt = stall_i ? 1 + rnd_q[17:16] : 1;
        end
      end
      if (wait_cnt > 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          mem_rsp_o.data  = rsp_line;
          mem_rsp_valid_o = 1'b1;
        end
      end
      // about one cycle in four without ready when stalling
      mem_req_ready_o = !stall_i || (rnd_q[29:28] != 2'b00);
    end
  end

endmodule

// File: tb/tb_dcache.sv
// testbench of the blocking data cache
//   clock, reset, directed and random stimulus, reference byte memory
//   response compare, watchdog and final report
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  localparam logic [31:0] SEED     = 32'h163f_d1db;
  localparam logic [31:0] BASE     = 32'h4000_0000;
  localparam int          N_RANDOM = 300;
  localparam int          N_DIRECT = 40;
  // worst case cycles per request with lookup, stalled request, 4 cycle latency and slack
  localparam int          MAX_REQ_CYCLES = 40;
  localparam int          TIMEOUT_NS = (10 + (N_RANDOM + N_DIRECT) * MAX_REQ_CYCLES) * 4;

  logic        clk;
  logic        rst_n;
  core_req_t   core_req;
  logic        core_req_valid;
  logic        core_req_ready;
  core_rsp_t   core_rsp;
  logic        core_rsp_valid;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  mem_rsp_t    mem_rsp;
  logic        mem_rsp_valid;
  logic        cfg_we;
  logic        cfg_enable;
  logic        stall_en;
  int unsigned line_rd_cnt;
  int unsigned word_rd_cnt;
  int unsigned wr_cnt;
  mem_req_t    last_req;

  // reference memory and bookkeeping
  logic [7:0]  ref_mem [4096];
  logic [63:0] exp_q [$];
  logic [63:0] exp_word;
  logic [31:0] rnd;
  string       test_name;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned err_base;
  int unsigned n_issued;
  int unsigned n_rsp;

  dcache_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .mem_req_o        (mem_req),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_rsp_i        (mem_rsp),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .cfg_we_i         (cfg_we),
    .cfg_enable_i     (cfg_enable)
  );

  tb_mem_model #(.BASE(BASE), .SEED(SEED ^ 32'h0000_ffff)) i_mem (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .stall_i         (stall_en),
    .mem_req_i       (mem_req),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_ready_o (mem_req_ready),
    .mem_rsp_o       (mem_rsp),
    .mem_rsp_valid_o (mem_rsp_valid),
    .line_rd_cnt_o   (line_rd_cnt),
    .word_rd_cnt_o   (word_rd_cnt),
    .wr_cnt_o        (wr_cnt),
    .last_req_o      (last_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rnd = rnd * 32'd1664525 + 32'd1013904223;
    return rnd;
  endfunction

  function automatic logic [31:0] line_addr(input int tag, input int idx, input int word);
    return BASE | (tag << 8) | (idx << 4) | (word << 3);
  endfunction

  // a load returns 8 reference bytes and a store merges its bytes and returns zero
  function automatic logic [63:0] ref_access(input core_req_t req);
    logic [63:0] word;
    logic [11:0] base;
    word = '0;
    base = {req.addr[11:3], 3'b000};
    for (int b = 0; b < 8; b++) begin
      if (!req.we) begin
        word[b*8 +: 8] = ref_mem[base + b];
      end else if (req.be[b]) begin
        ref_mem[base + b] = req.wdata[b*8 +: 8];
      end
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // hold valid and payload until the handshake edge
  task automatic access(input logic we, input logic [31:0] addr, input logic [7:0] be,
                        input logic [63:0] wdata);
    core_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = wdata;
    exp_q.push_back(ref_access(req));
    n_issued++;
    core_req       = req;
    core_req_valid = 1'b1;
    do @(posedge clk); while (!core_req_ready);
    #1;
    core_req_valid = 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  task automatic load_counted(input logic [31:0] addr, input int unsigned line_d,
                              input int unsigned word_d);
    int unsigned line0;
    int unsigned word0;
    line0 = line_rd_cnt;
    word0 = word_rd_cnt;
    access(1'b0, addr, '0, '0);
    wait_done();
    check_value({test_name, " line reads"}, line0 + line_d, line_rd_cnt);
    check_value({test_name, " word reads"}, word0 + word_d, word_rd_cnt);
  endtask

  // store must leave exactly one write-through with the same bytes
  task automatic store_checked(input logic [31:0] addr, input logic [7:0] be,
                               input logic [63:0] data);
    int unsigned wr0;
    int unsigned line0;
    wr0   = wr_cnt;
    line0 = line_rd_cnt;
    access(1'b1, addr, be, data);
    wait_done();
    check_value({test_name, " write count"}, wr0 + 1, wr_cnt);
    check_value({test_name, " write addr"}, addr, last_req.addr);
    check_value({test_name, " write be"}, be, last_req.be);
    check_value({test_name, " write data"}, data, last_req.wdata);
    check_value({test_name, " no allocate"}, line0, line_rd_cnt);
  endtask

  task automatic set_enable(input logic en);
    cfg_enable = en;
    cfg_we     = 1'b1;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    // pending value moves to active on the next idle edge
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = n_errors;
  endtask

  task automatic end_test();
    $display("test %s done, %0d errors", test_name, n_errors - err_base);
  endtask

  // ------------------------------------------------------------------------
  // response compare in request order
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && core_rsp_valid) begin
      n_rsp++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Error in %s: a response came with no request outstanding", test_name);
      end else begin
        exp_word = exp_q.pop_front();
        check_value(test_name, exp_word, core_rsp.rdata);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the cache did not finish all requests within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  initial begin
    int unsigned lat;
    int unsigned line0;
    logic [31:0] r;
    logic [31:0] addr;
    logic [63:0] data;
    rst_n          = 1'b0;
    core_req       = '0;
    core_req_valid = 1'b0;
    cfg_we         = 1'b0;
    cfg_enable     = 1'b1;
    stall_en       = 1'b0;
    rnd            = SEED;
    test_name      = "reset";
    n_checks       = 0;
    n_errors       = 0;
    n_issued       = 0;
    n_rsp          = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = i_mem.store_q[i];
    end

    start_test("reset_loads");
    check_value("reset ready", 1, core_req_ready);
    check_value("reset mem valid", 0, mem_req_valid);
    check_value("reset rsp valid", 0, core_rsp_valid);
    for (int s = 0; s < 6; s++) begin
      load_counted(line_addr(1, s, s % 2), 1, 0);
    end
    end_test();

    start_test("hit_repeat");
    line0 = line_rd_cnt;
    access(1'b0, line_addr(1, 2, 1), '0, '0);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!core_rsp_valid);
    wait_done();
    check_value("hit latency", 2, lat);
    check_value("hit line reads", line0, line_rd_cnt);
    load_counted(line_addr(1, 4, 0), 0, 0);
    end_test();

    start_test("store_merge");
    // store hit followed by a store miss that must not allocate
    store_checked(line_addr(1, 3, 0), 8'ha5, 64'h1122_3344_5566_7788);
    load_counted(line_addr(1, 3, 0), 0, 0);
    store_checked(line_addr(2, 7, 1), 8'h3c, 64'h99aa_bbcc_ddee_ff00);
    load_counted(line_addr(2, 7, 1), 1, 0);
    end_test();

    start_test("replacement");
    // in set 9 A fills way 0 and B way 1 before C evicts A and A evicts B
    load_counted(line_addr(3, 9, 0), 1, 0);
    load_counted(line_addr(4, 9, 0), 1, 0);
    load_counted(line_addr(5, 9, 1), 1, 0);
    load_counted(line_addr(4, 9, 1), 0, 0);
    load_counted(line_addr(3, 9, 0), 1, 0);
    load_counted(line_addr(5, 9, 0), 0, 0);
    load_counted(line_addr(4, 9, 0), 1, 0);
    end_test();

    start_test("bypass");
    set_enable(1'b0);
    load_counted(line_addr(4, 9, 0), 0, 1);
    store_checked(line_addr(4, 9, 0), 8'h0f, 64'h0bad_cafe_dead_beef);
    load_counted(line_addr(1, 0, 0), 0, 1);
    set_enable(1'b1);
    // both lines were resident before the switch and the flush drops them
    load_counted(line_addr(4, 9, 0), 1, 0);
    load_counted(line_addr(1, 0, 0), 1, 0);
    end_test();

    start_test("random");
    stall_en = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      r    = lcg_next();
      addr = BASE | (lcg_next() & 32'h0000_0ff8);
      data = {lcg_next(), lcg_next()};
      access(r[31:29] < 3'd3, addr, r[15:8], data);
    end
    wait_done();
    stall_en = 1'b0;
    check_value("response count", n_issued, n_rsp);
    end_test();

    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             n_checks, n_errors, n_issued, n_rsp);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_cfg_regs.sv
hdl/dcache_arrays.sv
hdl/dcache_ctrl_fsm.sv
hdl/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv
